//--- hdl/isa_pkg.sv
package isa_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      reg_addr_t;

    // Opcodes, bits 31:26
    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_ADDIU = 6'h09;
    localparam logic [5:0] OP_ORI   = 6'h0d;
    localparam logic [5:0] OP_LUI   = 6'h0f;
    localparam logic [5:0] OP_LW    = 6'h23;
    localparam logic [5:0] OP_SW    = 6'h2b;

    // R-format funct, bits 5:0
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_SLT  = 6'h2a;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,             // Zero value, so a bubble decodes as add
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_SLT = 3'd4,
        ALU_LUI = 3'd5
    } alu_op_e;

    typedef struct packed {
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    alu_src_imm;       // Operand B from immediate
        alu_op_e alu_op;
    } ctrl_t;

    typedef struct packed {
        word_t instr;
    } if_id_t;

    typedef struct packed {
        ctrl_t     ctrl;
        word_t     rs_val;
        word_t     rt_val;
        word_t     imm;             // Already extended
        reg_addr_t rs;
        reg_addr_t rt;
        reg_addr_t dest;
    } id_ex_t;

    typedef struct packed {
        ctrl_t     ctrl;
        word_t     alu_result;      // Also the memory address
        word_t     store_data;
        reg_addr_t dest;
    } ex_mem_t;

    typedef struct packed {
        logic      reg_write;
        word_t     wb_data;
        reg_addr_t dest;
    } mem_wb_t;

endpackage

//--- hdl/io_map_pkg.sv
package io_map_pkg;

    // Top 1 KiB of the address space is I/O
    localparam logic [31:0] IO_BASE = 32'hFFFF_FC00;

    localparam int IO_OFFSET_W = 10;

    // Register offsets inside the I/O region
    localparam logic [IO_OFFSET_W-1:0] LED_OFFSET    = 10'h060;
    localparam logic [IO_OFFSET_W-1:0] SWITCH_OFFSET = 10'h070;

    localparam int LED_WIDTH    = 24;
    localparam int SWITCH_WIDTH = 24;

endpackage

//--- hdl/io_bus_if.sv
`timescale 1ns/1ps

interface io_bus_if;
    logic        rd;                // Level, held for the whole access
    logic        wr;                // One-cycle strobe
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [31:0] rdata;             // Combinational answer to rd

    modport host (
        output rd, wr, addr, wdata,
        input  rdata
    );

    modport port (
        input  rd, wr, addr, wdata,
        output rdata
    );
endinterface

//--- hdl/pipe_reg.sv
`timescale 1ns/1ps

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     fpga_clk,
    input  logic     fpga_rst,
    input  logic     hold_i,
    input  logic     bubble_i,
    input  payload_t d_i,
    output payload_t q_o
);

    // All-zero payload carries no side effects
    always_ff @(posedge fpga_clk) begin
        if (fpga_rst || bubble_i) begin
            q_o <= '0;
        end else if (!hold_i) begin
            q_o <= d_i;
        end
    end

endmodule

//--- hdl/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage #(
    parameter int IMEM_WORDS = 256
) (
    input  logic                          fpga_clk,
    input  logic                          fpga_rst,
    input  logic                          stall_i,
    input  logic                          prog_we_i,
    input  logic [$clog2(IMEM_WORDS)-1:0] prog_addr_i,
    input  isa_pkg::word_t                prog_data_i,
    output isa_pkg::if_id_t               instr_o
);
    import isa_pkg::*;

    localparam int IMEM_AW = $clog2(IMEM_WORDS);

    word_t               rom [IMEM_WORDS];
    word_t               pc;
    logic [IMEM_AW-1:0]  pc_idx;

    // Straight-line code, PC just runs on and wraps with the index
    always_ff @(posedge fpga_clk) begin
        if (fpga_rst) begin
            pc <= '0;
        end else if (!stall_i) begin
            pc <= pc + 32'd4;
        end
    end

    // Program load port, open during reset as well
    always_ff @(posedge fpga_clk) begin
        if (prog_we_i) begin
            rom[prog_addr_i] <= prog_data_i;
        end
    end

    assign pc_idx        = pc[IMEM_AW+1:2];   // Word index
    assign instr_o.instr = rom[pc_idx];        // Captured by if_id at cycle end

endmodule

//--- hdl/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
    input  logic             fpga_clk,
    input  logic             fpga_rst,
    input  isa_pkg::if_id_t  if_id_i,
    input  isa_pkg::id_ex_t  ex_load_i,
    input  isa_pkg::mem_wb_t wb_i,
    output logic             stall_o,
    output isa_pkg::id_ex_t  id_ex_o
);
    import isa_pkg::*;

    word_t      regs [32];
    logic [5:0] opcode;
    logic [5:0] funct;
    reg_addr_t  rs;
    reg_addr_t  rt;
    reg_addr_t  rd;
    logic [15:0] imm16;
    ctrl_t      ctrl;
    logic       zero_ext;
    logic       wb_en;

    assign opcode = if_id_i.instr[31:26];
    assign rs     = if_id_i.instr[25:21];
    assign rt     = if_id_i.instr[20:16];
    assign rd     = if_id_i.instr[15:11];
    assign imm16  = if_id_i.instr[15:0];
    assign funct  = if_id_i.instr[5:0];

    assign wb_en = wb_i.reg_write && (wb_i.dest != '0);   // $0 never written

    always_ff @(posedge fpga_clk) begin
        if (fpga_rst) begin
            regs <= '{default: '0};
        end else if (wb_en) begin
            regs[wb_i.dest] <= wb_i.wb_data;
        end
    end

    always_comb begin
        ctrl = '0;                          // Unknown encodings stay no-ops
        case (opcode)
            OP_RTYPE: begin
                ctrl.reg_write = 1'b1;
                case (funct)
                    FN_ADDU: ctrl.alu_op = ALU_ADD;
                    FN_SUBU: ctrl.alu_op = ALU_SUB;
                    FN_AND:  ctrl.alu_op = ALU_AND;
                    FN_OR:   ctrl.alu_op = ALU_OR;
                    FN_SLT:  ctrl.alu_op = ALU_SLT;
                    default: ctrl.reg_write = 1'b0;
                endcase
            end
            OP_ADDIU: begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
            end
            OP_ORI: begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.alu_op      = ALU_OR;
            end
            OP_LUI: begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.alu_op      = ALU_LUI;
            end
            OP_LW: begin
                ctrl.reg_write   = 1'b1;
                ctrl.mem_read    = 1'b1;
                ctrl.alu_src_imm = 1'b1;
            end
            OP_SW: begin
                ctrl.mem_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
            end
            default: ;
        endcase
    end

    // Logical immediates are zero-extended
    assign zero_ext = (opcode == OP_ORI) || (opcode == OP_LUI);

    always_comb begin
        id_ex_o.ctrl   = ctrl;
        // Same-cycle write-back is seen by the read
        id_ex_o.rs_val = (rs == '0) ? '0 :
                         (wb_en && wb_i.dest == rs) ? wb_i.wb_data : regs[rs];
        id_ex_o.rt_val = (rt == '0) ? '0 :
                         (wb_en && wb_i.dest == rt) ? wb_i.wb_data : regs[rt];
        id_ex_o.imm    = zero_ext ? {16'h0, imm16} : {{16{imm16[15]}}, imm16};
        id_ex_o.rs     = rs;
        id_ex_o.rt     = rt;
        id_ex_o.dest   = (opcode == OP_RTYPE) ? rd : rt;
    end

    // Load in execute feeding this instruction
    assign stall_o = ex_load_i.ctrl.mem_read && (ex_load_i.dest != '0) &&
                     ((ex_load_i.dest == rs) || (ex_load_i.dest == rt));

endmodule

//--- hdl/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
    input  isa_pkg::id_ex_t  id_ex_i,
    input  isa_pkg::ex_mem_t ex_mem_fwd_i,
    input  isa_pkg::mem_wb_t mem_wb_fwd_i,
    output isa_pkg::ex_mem_t ex_mem_o
);
    import isa_pkg::*;

    word_t op_a;
    word_t fwd_b;
    word_t op_b;
    word_t result;
    logic  mem_hit_a;
    logic  mem_hit_b;
    logic  wb_hit_a;
    logic  wb_hit_b;

    // Nearer stage wins
    assign mem_hit_a = ex_mem_fwd_i.ctrl.reg_write && (ex_mem_fwd_i.dest != '0) &&
                       (ex_mem_fwd_i.dest == id_ex_i.rs);
    assign mem_hit_b = ex_mem_fwd_i.ctrl.reg_write && (ex_mem_fwd_i.dest != '0) &&
                       (ex_mem_fwd_i.dest == id_ex_i.rt);
    assign wb_hit_a  = mem_wb_fwd_i.reg_write && (mem_wb_fwd_i.dest != '0) &&
                       (mem_wb_fwd_i.dest == id_ex_i.rs);
    assign wb_hit_b  = mem_wb_fwd_i.reg_write && (mem_wb_fwd_i.dest != '0) &&
                       (mem_wb_fwd_i.dest == id_ex_i.rt);

    assign op_a  = mem_hit_a ? ex_mem_fwd_i.alu_result :
                   wb_hit_a  ? mem_wb_fwd_i.wb_data    : id_ex_i.rs_val;
    assign fwd_b = mem_hit_b ? ex_mem_fwd_i.alu_result :
                   wb_hit_b  ? mem_wb_fwd_i.wb_data    : id_ex_i.rt_val;
    assign op_b  = id_ex_i.ctrl.alu_src_imm ? id_ex_i.imm : fwd_b;

    always_comb begin
        case (id_ex_i.ctrl.alu_op)
            ALU_ADD: result = op_a + op_b;
            ALU_SUB: result = op_a - op_b;
            ALU_AND: result = op_a & op_b;
            ALU_OR:  result = op_a | op_b;
            ALU_SLT: result = {31'h0, $signed(op_a) < $signed(op_b)};
            ALU_LUI: result = {op_b[15:0], 16'h0};
            default: result = '0;
        endcase
    end

    assign ex_mem_o.ctrl       = id_ex_i.ctrl;
    assign ex_mem_o.alu_result = result;
    assign ex_mem_o.store_data = fwd_b;             // sw needs the forwarded rt
    assign ex_mem_o.dest       = id_ex_i.dest;

endmodule

//--- hdl/memory_stage.sv
`timescale 1ns/1ps

module memory_stage #(
    parameter int DMEM_WORDS = 256
) (
    input  logic             fpga_clk,
    input  isa_pkg::ex_mem_t ex_mem_i,
    io_bus_if.host           io,
    output isa_pkg::mem_wb_t mem_wb_o
);
    import isa_pkg::*;
    import io_map_pkg::*;

    localparam int DMEM_AW = $clog2(DMEM_WORDS);

    word_t              ram [DMEM_WORDS];
    logic               is_io;
    logic [DMEM_AW-1:0] ram_idx;
    word_t              load_data;

    assign is_io   = ex_mem_i.alu_result >= IO_BASE;
    assign ram_idx = ex_mem_i.alu_result[DMEM_AW+1:2];   // Word address wraps

    always_ff @(posedge fpga_clk) begin
        if (ex_mem_i.ctrl.mem_write && !is_io) begin
            ram[ram_idx] <= ex_mem_i.store_data;
        end
    end

    assign io.rd    = ex_mem_i.ctrl.mem_read && is_io;
    assign io.wr    = ex_mem_i.ctrl.mem_write && is_io;
    assign io.addr  = ex_mem_i.alu_result;
    assign io.wdata = ex_mem_i.store_data;

    assign load_data = is_io ? io.rdata : ram[ram_idx];

    assign mem_wb_o.reg_write = ex_mem_i.ctrl.reg_write;
    assign mem_wb_o.wb_data   = ex_mem_i.ctrl.mem_read ? load_data : ex_mem_i.alu_result;
    assign mem_wb_o.dest      = ex_mem_i.dest;

endmodule

//--- hdl/io_ports.sv
`timescale 1ns/1ps

module io_ports (
    input  logic                                fpga_clk,
    input  logic                                fpga_rst,
    io_bus_if.port                              bus,
    input  logic [io_map_pkg::SWITCH_WIDTH-1:0] switch_i,
    output logic [io_map_pkg::LED_WIDTH-1:0]    led_o
);
    import io_map_pkg::*;

    logic [IO_OFFSET_W-1:0] offset;

    // Region already decoded by the host
    assign offset = bus.addr[IO_OFFSET_W-1:0];

    always_ff @(posedge fpga_clk) begin
        if (fpga_rst) begin
            led_o <= '0;
        end else if (bus.wr && offset == LED_OFFSET) begin
            led_o <= bus.wdata[LED_WIDTH-1:0];
        end
    end

    always_comb begin
        bus.rdata = '0;                     // Unmapped offsets read zero
        if (bus.rd && offset == SWITCH_OFFSET) begin
            bus.rdata = 32'(switch_i);
        end
    end

endmodule

//--- hdl/minisys_top.sv
`timescale 1ns/1ps

module minisys_top #(
    parameter int IMEM_WORDS = 256,
    parameter int DMEM_WORDS = 256
) (
    input  logic                                fpga_clk,
    input  logic                                fpga_rst,
    input  logic                                prog_we_i,
    input  logic [$clog2(IMEM_WORDS)-1:0]       prog_addr_i,
    input  isa_pkg::word_t                      prog_data_i,
    input  logic [io_map_pkg::SWITCH_WIDTH-1:0] switch_i,
    output logic [io_map_pkg::LED_WIDTH-1:0]    led_o
);
    import isa_pkg::*;

    if_id_t  fetch_out;
    if_id_t  if_id_q;
    id_ex_t  decode_out;
    id_ex_t  id_ex_q;
    ex_mem_t exec_out;
    ex_mem_t ex_mem_q;
    mem_wb_t mem_out;
    mem_wb_t mem_wb_q;
    logic    stall;

    io_bus_if io_bus ();

    fetch_stage #(.IMEM_WORDS(IMEM_WORDS)) u_fetch (
        .fpga_clk    (fpga_clk),
        .fpga_rst    (fpga_rst),
        .stall_i     (stall),
        .prog_we_i   (prog_we_i),
        .prog_addr_i (prog_addr_i),
        .prog_data_i (prog_data_i),
        .instr_o     (fetch_out)
    );

    pipe_reg #(.payload_t(if_id_t)) if_id (
        .fpga_clk (fpga_clk),
        .fpga_rst (fpga_rst),
        .hold_i   (stall),              // Stalled instruction waits in decode
        .bubble_i (1'b0),
        .d_i      (fetch_out),
        .q_o      (if_id_q)
    );

    decode_stage u_decode (
        .fpga_clk  (fpga_clk),
        .fpga_rst  (fpga_rst),
        .if_id_i   (if_id_q),
        .ex_load_i (id_ex_q),
        .wb_i      (mem_wb_q),
        .stall_o   (stall),
        .id_ex_o   (decode_out)
    );

    pipe_reg #(.payload_t(id_ex_t)) id_ex (
        .fpga_clk (fpga_clk),
        .fpga_rst (fpga_rst),
        .hold_i   (1'b0),
        .bubble_i (stall),              // Bubble behind the load
        .d_i      (decode_out),
        .q_o      (id_ex_q)
    );

    execute_stage u_execute (
        .id_ex_i      (id_ex_q),
        .ex_mem_fwd_i (ex_mem_q),
        .mem_wb_fwd_i (mem_wb_q),
        .ex_mem_o     (exec_out)
    );

    pipe_reg #(.payload_t(ex_mem_t)) ex_mem (
        .fpga_clk (fpga_clk),
        .fpga_rst (fpga_rst),
        .hold_i   (1'b0),
        .bubble_i (1'b0),
        .d_i      (exec_out),
        .q_o      (ex_mem_q)
    );

    memory_stage #(.DMEM_WORDS(DMEM_WORDS)) u_memory (
        .fpga_clk (fpga_clk),
        .ex_mem_i (ex_mem_q),
        .io       (io_bus.host),
        .mem_wb_o (mem_out)
    );

    pipe_reg #(.payload_t(mem_wb_t)) mem_wb (
        .fpga_clk (fpga_clk),
        .fpga_rst (fpga_rst),
        .hold_i   (1'b0),
        .bubble_i (1'b0),
        .d_i      (mem_out),
        .q_o      (mem_wb_q)
    );

    io_ports u_io (
        .fpga_clk (fpga_clk),
        .fpga_rst (fpga_rst),
        .bus      (io_bus.port),
        .switch_i (switch_i),
        .led_o    (led_o)
    );

endmodule

//--- dv/minisys_properties.sv
`timescale 1ns/1ps

module minisys_properties (
    input logic        fpga_clk,
    input logic        fpga_rst,
    input logic [23:0] led_o,
    input logic        stall,
    input logic        bus_rd,
    input logic        bus_wr
);

    // LED register comes out of reset cleared
    led_reset_zero: assert property (@(posedge fpga_clk) fpga_rst |=> led_o == '0)
        else $error("led_o not zero in the cycle after reset");

    // One bubble per load-use pair
    stall_single_cycle: assert property (
        @(posedge fpga_clk) disable iff (fpga_rst) stall |=> !stall
    ) else $error("stall held for two consecutive cycles");

    bus_rd_wr_exclusive: assert property (
        @(posedge fpga_clk) disable iff (fpga_rst) !(bus_rd && bus_wr)
    ) else $error("I/O bus rd and wr high together");

endmodule

bind minisys_top minisys_properties props_i (
    .fpga_clk (fpga_clk),
    .fpga_rst (fpga_rst),
    .led_o    (led_o),
    .stall    (stall),
    .bus_rd   (io_bus.rd),
    .bus_wr   (io_bus.wr)
);

//--- dv/tb_minisys.sv
`timescale 1ns/1ps

module tb_minisys;
    import isa_pkg::*;
    import io_map_pkg::*;

    localparam word_t LED_ADDR = IO_BASE + word_t'(LED_OFFSET);
    localparam word_t SW_ADDR  = IO_BASE + word_t'(SWITCH_OFFSET);

    logic                    fpga_clk;
    logic                    fpga_rst;
    logic                    prog_we_i;
    logic [7:0]              prog_addr_i;
    word_t                   prog_data_i;
    logic [SWITCH_WIDTH-1:0] switch_i;
    logic [LED_WIDTH-1:0]    led_o;

    word_t prog[$];                 // Program under construction
    int    errors;
    int    checks;

    minisys_top dut_i (
        .fpga_clk    (fpga_clk),
        .fpga_rst    (fpga_rst),
        .prog_we_i   (prog_we_i),
        .prog_addr_i (prog_addr_i),
        .prog_data_i (prog_data_i),
        .switch_i    (switch_i),
        .led_o       (led_o)
    );

    initial begin
        fpga_clk = 1'b0;
        forever #50 fpga_clk = ~fpga_clk;
    end

    function automatic word_t rtype_word(logic [5:0] funct, reg_addr_t rd, reg_addr_t rs,
                                         reg_addr_t rt);
        return {OP_RTYPE, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic word_t itype_word(logic [5:0] op, reg_addr_t rt, reg_addr_t rs,
                                         logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t sext(logic [15:0] v);
        return {{16{v[15]}}, v};
    endfunction

    task automatic check(string name, word_t expected, word_t actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("error %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // ROM is written under reset, then reset stays up 5 more cycles
    task automatic load_program();
        int a;
        @(posedge fpga_clk);
        #10;
        fpga_rst = 1'b1;
        for (a = 0; a < 256; a++) begin
            @(posedge fpga_clk);
            #10;
            prog_we_i   = 1'b1;
            prog_addr_i = 8'(a);
            prog_data_i = (a < prog.size()) ? prog[a] : '0;   // Zero pad is a no-op
        end
        @(posedge fpga_clk);
        #10;
        prog_we_i = 1'b0;
        repeat (5) begin
            @(posedge fpga_clk);
            #10;
        end
        fpga_rst = 1'b0;
    endtask

    task automatic wait_led(input logic [LED_WIDTH-1:0] expected, output bit reached);
        int cycles;
        reached = 1'b0;
        for (cycles = 0; cycles < 200 && !reached; cycles++) begin
            @(posedge fpga_clk);
            #10;
            if (led_o === expected) reached = 1'b1;
        end
        if (!reached) begin
            errors++;
            $display("LED never reached %h within 200 cycles, it shows %h", expected, led_o);
        end
    endtask

    task automatic run_program(string name, logic [LED_WIDTH-1:0] expected);
        bit reached;
        load_program();
        wait_led(expected, reached);
        if (reached) begin
            // LED is written once, so it must stay put
            repeat (20) @(posedge fpga_clk);
            #10;
            check(name, word_t'(expected), word_t'(led_o));
        end
        prog.delete();
    endtask

    task automatic after_reset();
        prog.delete();
        load_program();
        @(posedge fpga_clk);
        #10;
        check("after_reset led", '0, word_t'(led_o));
        check("after_reset stall", '0, word_t'(dut_i.stall));
    endtask

    task automatic alu_forwarding();
        word_t r1, r2, r3, r4, r5, r6, r7, r8;
        r1 = sext(16'hF234);                    // Negative immediate
        r2 = {16'h00AB, 16'h0000};
        r2 = r2 | {16'h0000, 16'h5678};
        r3 = r2 + r1;
        r4 = r3 - r1;
        r5 = r4 & r3;
        r6 = r5 | r1;
        r7 = ($signed(r1) < $signed(r6)) ? 32'd1 : 32'd0;
        r8 = r6 + r7;
        prog.push_back(itype_word(OP_ADDIU, 5'd1, 5'd0, 16'hF234));
        prog.push_back(itype_word(OP_LUI, 5'd2, 5'd0, 16'h00AB));
        prog.push_back(itype_word(OP_ORI, 5'd2, 5'd2, 16'h5678));
        prog.push_back(rtype_word(FN_ADDU, 5'd3, 5'd2, 5'd1));
        prog.push_back(rtype_word(FN_SUBU, 5'd4, 5'd3, 5'd1));
        prog.push_back(rtype_word(FN_AND, 5'd5, 5'd4, 5'd3));
        prog.push_back(rtype_word(FN_OR, 5'd6, 5'd5, 5'd1));
        prog.push_back(rtype_word(FN_SLT, 5'd7, 5'd1, 5'd6));
        prog.push_back(rtype_word(FN_ADDU, 5'd8, 5'd6, 5'd7));
        prog.push_back(itype_word(OP_SW, 5'd8, 5'd0, LED_ADDR[15:0]));
        run_program("alu_forwarding", r8[LED_WIDTH-1:0]);
    endtask

    task automatic load_use_switch();
        word_t sum;
        @(posedge fpga_clk);
        #10;
        switch_i = SWITCH_WIDTH'($urandom);
        sum = word_t'(switch_i) + sext(16'h0123);
        prog.push_back(itype_word(OP_LW, 5'd1, 5'd0, SW_ADDR[15:0]));
        prog.push_back(itype_word(OP_ADDIU, 5'd2, 5'd1, 16'h0123));   // Uses the load at once
        prog.push_back(itype_word(OP_SW, 5'd2, 5'd0, LED_ADDR[15:0]));
        run_program("load_use_switch", sum[LED_WIDTH-1:0]);
    endtask

    task automatic data_ram();
        word_t sum;
        sum = sext(16'h1357) + sext(16'h2468);
        prog.push_back(itype_word(OP_ADDIU, 5'd1, 5'd0, 16'h1357));
        prog.push_back(itype_word(OP_ADDIU, 5'd2, 5'd0, 16'h2468));
        prog.push_back(itype_word(OP_SW, 5'd1, 5'd0, 16'h0010));
        prog.push_back(itype_word(OP_SW, 5'd2, 5'd0, 16'h0024));
        prog.push_back(itype_word(OP_LW, 5'd3, 5'd0, 16'h0010));
        prog.push_back(itype_word(OP_LW, 5'd4, 5'd0, 16'h0024));
        prog.push_back(rtype_word(FN_ADDU, 5'd5, 5'd3, 5'd4));
        prog.push_back(itype_word(OP_SW, 5'd5, 5'd0, LED_ADDR[15:0]));
        run_program("data_ram", sum[LED_WIDTH-1:0]);
    endtask

    task automatic zero_reg_noops();
        prog.push_back(itype_word(OP_ADDIU, 5'd1, 5'd0, 16'h0042));
        prog.push_back(32'h0000_0000);
        prog.push_back(rtype_word(6'h18, 5'd1, 5'd1, 5'd1));          // Unsupported mult
        prog.push_back(itype_word(6'h08, 5'd1, 5'd0, 16'h7777));      // Unsupported addi
        prog.push_back(32'hFFFF_FFFF);
        // Both $0 writes sit in memory and writeback when the addu executes
        prog.push_back(itype_word(OP_ADDIU, 5'd0, 5'd0, 16'h5555));
        prog.push_back(itype_word(OP_ADDIU, 5'd0, 5'd0, 16'h0AAA));
        prog.push_back(rtype_word(FN_ADDU, 5'd2, 5'd1, 5'd0));
        prog.push_back(itype_word(OP_SW, 5'd2, 5'd0, LED_ADDR[15:0]));
        run_program("zero_reg_noops", 24'h000042);
    endtask

    task automatic random_chains();
        logic [15:0] i0, i1, i2;
        word_t       r1, r2, r3, r4;
        for (int run = 0; run < 10; run++) begin
            i0 = 16'($urandom);
            i1 = 16'($urandom);
            i2 = 16'($urandom);
            r1 = sext(i0);
            r2 = r1 + sext(i1);
            r3 = r2 + r1;
            r3 = r3 + sext(i2);
            r4 = r3 + r2;
            prog.push_back(itype_word(OP_ADDIU, 5'd1, 5'd0, i0));
            prog.push_back(itype_word(OP_ADDIU, 5'd2, 5'd1, i1));
            prog.push_back(rtype_word(FN_ADDU, 5'd3, 5'd2, 5'd1));
            prog.push_back(itype_word(OP_ADDIU, 5'd3, 5'd3, i2));
            prog.push_back(rtype_word(FN_ADDU, 5'd4, 5'd3, 5'd2));
            prog.push_back(itype_word(OP_SW, 5'd4, 5'd0, LED_ADDR[15:0]));
            run_program($sformatf("random_chains run %0d", run), r4[LED_WIDTH-1:0]);
        end
    endtask

    initial begin
        fpga_rst    = 1'b1;
        prog_we_i   = 1'b0;
        prog_addr_i = '0;
        prog_data_i = '0;
        switch_i    = '0;
        errors      = 0;
        checks      = 0;
        void'($urandom(85262));

        after_reset();
        alu_forwarding();
        load_use_switch();
        data_ram();
        zero_reg_noops();
        random_chains();

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- project.f
hdl/isa_pkg.sv
hdl/io_map_pkg.sv
hdl/io_bus_if.sv
hdl/pipe_reg.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/memory_stage.sv
hdl/io_ports.sv
hdl/minisys_top.sv
dv/minisys_properties.sv
dv/tb_minisys.sv
